//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = fpga_panel_tb
FILELIST = fpga_panel.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- design/board_pkg.sv
package board_pkg;

   // --------------------------------------------------
   // front panel buttons
   // --------------------------------------------------

   localparam int num_buttons = 4;

   // clk100 cycles a synchronized level must hold before it counts
   localparam int debounce_cycles = 16;
   localparam int debounce_w = $clog2(debounce_cycles);

   // button positions on the board connector
   typedef enum logic [1:0] {
      btn_cont  = 2'd0,
      btn_halt  = 2'd1,
      btn_boot  = 2'd2,
      btn_reset = 2'd3
   } btn_t;

   // --------------------------------------------------
   // processor control timing
   // --------------------------------------------------

   localparam int reset_hold_cycles = 8;    // cpu_reset length after a reset request
   localparam int hold_w = $clog2(reset_hold_cycles);

   // step rate select, switch 6 gives the slowest rate
   localparam int rate_slow_log = 12;
   localparam int rate_log_w = $clog2(rate_slow_log + 1);

   // seven switch positions plus the full speed entry
   localparam int num_rates = 8;
   localparam int rate_sel_w = $clog2(num_rates);

endpackage

//--- design/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner (
   input  logic                              clk100,
   input  logic                              reset,
   input  logic [board_pkg::num_buttons-1:0] button,
   panel_if.source                           events
);
   import board_pkg::*;

   logic [num_buttons-1:0] sync1;
   logic [num_buttons-1:0] sync2;
   logic [num_buttons-1:0] deb;      // debounced level
   logic [num_buttons-1:0] deb_q;
   logic [num_buttons-1:0] press;
   logic [debounce_w-1:0]  steady [num_buttons];

   // --------------------------------------------------
   // two flop synchronizer, buttons are asynchronous
   // --------------------------------------------------

   always_ff @(posedge clk100) begin
      if (reset) begin
         sync1 <= '0;
         sync2 <= '0;
      end else begin
         sync1 <= button;
         sync2 <= sync1;
      end
   end

   // --------------------------------------------------
   // per button steady counter
   // --------------------------------------------------

   // counter restarts whenever the synchronized level agrees with
   // the debounced level, so any glitch back reloads it
   always_ff @(posedge clk100) begin
      if (reset) begin
         for (int i = 0; i < num_buttons; i++) begin
            steady[i] <= '0;
         end
         deb <= '0;
      end else begin
         for (int i = 0; i < num_buttons; i++) begin
            if (sync2[i] == deb[i]) begin
               steady[i] <= '0;
            end else if (steady[i] == debounce_w'(debounce_cycles - 1)) begin
               deb[i]    <= sync2[i];   // held long enough, accept it
               steady[i] <= '0;
            end else begin
               steady[i] <= steady[i] + 1'b1;
            end
         end
      end
   end

   // rising edge of the debounced level, releases are dropped
   always_ff @(posedge clk100) begin
      if (reset) begin
         deb_q <= '0;
         press <= '0;
      end else begin
         deb_q <= deb;
         press <= deb & ~deb_q;
      end
   end

   assign events.reset_press = press[btn_reset];
   assign events.boot_press  = press[btn_boot];
   assign events.halt_press  = press[btn_halt];
   assign events.cont_press  = press[btn_cont];

endmodule

//--- design/fpga_panel.sv
`timescale 1ns/1ps

module fpga_panel (
   input  logic                             clk100,
   input  logic                             reset,
   input  logic [board_pkg::num_buttons-1:0] button,
   input  logic [7:0]                       slideswitch,
   input  logic [panel_pkg::pc_width-1:0]   pc,
   input  logic [panel_pkg::num_digits-1:0] dots,
   output logic                             cpu_reset,
   output logic                             cpu_boot,
   output logic                             cpu_halt,
   output logic                             cpu_step,
   output logic [7:0]                       sevenseg,
   output logic [panel_pkg::num_digits-1:0] sevenseg_an
);

   // --------------------------------------------------
   // buttons to press events
   // --------------------------------------------------

   panel_if events ();

   button_conditioner buttons (
      .clk100 (clk100),
      .reset  (reset),
      .button (button),
      .events (events.source)
   );

   // --------------------------------------------------
   // processor controls
   // --------------------------------------------------

   run_control control (
      .clk100      (clk100),
      .reset       (reset),
      .events      (events.sink),
      .slideswitch (slideswitch),
      .cpu_reset   (cpu_reset),
      .cpu_boot    (cpu_boot),
      .cpu_halt    (cpu_halt),
      .cpu_step    (cpu_step)
   );

   // --------------------------------------------------
   // pc on the seven segment display
   // --------------------------------------------------

   pc_display show_pc (
      .clk100      (clk100),
      .reset       (reset),
      .pc          (pc),
      .dots        (dots),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

endmodule

//--- design/panel_if.sv
`timescale 1ns/1ps

// debounced button events, one clk100 strobe per press
interface panel_if;

   logic reset_press;
   logic boot_press;
   logic halt_press;
   logic cont_press;

   modport source (
      output reset_press,
      output boot_press,
      output halt_press,
      output cont_press
   );

   modport sink (
      input reset_press,
      input boot_press,
      input halt_press,
      input cont_press
   );

endinterface

//--- design/panel_pkg.sv
package panel_pkg;

   // --------------------------------------------------
   // run sequencer
   // --------------------------------------------------

   typedef enum logic [2:0] {
      st_power_on,   // reset held after board reset
      st_reset,      // reset held after a reset button press
      st_boot,       // single boot pulse
      st_run,
      st_halted
   } seq_state_t;

   // --------------------------------------------------
   // seven segment display
   // --------------------------------------------------

   localparam int num_digits = 4;
   localparam int digit_w = $clog2(num_digits);

   // dwell time of one digit in clk100 cycles
   localparam int digit_cycles = 8;
   localparam int dwell_w = $clog2(digit_cycles);

   localparam int pc_width = 14;   // microcode pc, top digit shows two bits

endpackage

//--- design/pc_display.sv
`timescale 1ns/1ps

module pc_display (
   input  logic                             clk100,
   input  logic                             reset,
   input  logic [panel_pkg::pc_width-1:0]   pc,
   input  logic [panel_pkg::num_digits-1:0] dots,
   output logic [7:0]                       sevenseg,
   output logic [panel_pkg::num_digits-1:0] sevenseg_an
);
   import panel_pkg::*;

   logic [dwell_w-1:0]      dwell;
   logic [digit_w-1:0]      digit;    // digit being driven
   logic [num_digits*4-1:0] pc_ext;
   logic [3:0]              nibble;

   // segments a..g in bits 0..6, low lights the segment
   function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
      case (value)
         4'h0:    return 7'h40;
         4'h1:    return 7'h79;
         4'h2:    return 7'h24;
         4'h3:    return 7'h30;
         4'h4:    return 7'h19;
         4'h5:    return 7'h12;
         4'h6:    return 7'h02;
         4'h7:    return 7'h78;
         4'h8:    return 7'h00;
         4'h9:    return 7'h10;
         4'ha:    return 7'h08;
         4'hb:    return 7'h03;
         4'hc:    return 7'h46;
         4'hd:    return 7'h21;
         4'he:    return 7'h06;
         default: return 7'h0e;
      endcase
   endfunction

   // --------------------------------------------------
   // digit scan
   // --------------------------------------------------

   always_ff @(posedge clk100) begin
      if (reset) begin
         dwell       <= '0;
         digit       <= '0;
         sevenseg_an <= {{(num_digits - 1){1'b1}}, 1'b0};   // digit 0 lit
      end else begin
         if (dwell == dwell_w'(digit_cycles - 1)) begin
            dwell <= '0;
            if (digit == digit_w'(num_digits - 1)) begin
               digit <= '0;
            end else begin
               digit <= digit + 1'b1;
            end
         end else begin
            dwell <= dwell + 1'b1;
         end
         sevenseg_an <= ~(num_digits'(1) << digit);   // anodes are active low
      end
   end

   // --------------------------------------------------
   // segment data
   // --------------------------------------------------

   // top digit only has pc bits 13:12 under it
   assign pc_ext = {{(num_digits * 4 - pc_width){1'b0}}, pc};
   assign nibble = pc_ext[digit*4 +: 4];

   always_ff @(posedge clk100) begin
      sevenseg <= {~dots[digit], hex_to_seg(nibble)};   // dot is bit 7
   end

endmodule

//--- design/run_control.sv
`timescale 1ns/1ps

module run_control (
   input  logic       clk100,
   input  logic       reset,
   panel_if.sink      events,
   input  logic [7:0] slideswitch,
   output logic       cpu_reset,
   output logic       cpu_boot,
   output logic       cpu_halt,
   output logic       cpu_step
);
   import board_pkg::*;
   import panel_pkg::*;

   seq_state_t               state;
   logic [hold_w-1:0]        hold;
   logic [rate_slow_log-1:0] rate_cnt;
   logic [rate_sel_w-1:0]    rate_sel;
   logic [rate_log_w-1:0]    rate_log;
   logic [rate_slow_log-1:0] rate_mask;

   // --------------------------------------------------
   // reset, boot, run, halt sequencer
   // --------------------------------------------------

   always_ff @(posedge clk100) begin
      if (reset) begin
         state <= st_power_on;
         hold  <= '0;
      end else if (events.reset_press) begin
         state <= st_reset;   // restarts from anywhere
         hold  <= '0;
      end else begin
         case (state)
            st_power_on, st_reset: begin
               if (hold == hold_w'(reset_hold_cycles - 1)) begin
                  state <= st_boot;
               end else begin
                  hold <= hold + 1'b1;
               end
            end
            st_boot: state <= st_run;
            st_run: begin
               if (events.boot_press) begin   // boot wins over halt
                  state <= st_boot;
               end else if (events.halt_press) begin
                  state <= st_halted;
               end
            end
            st_halted: begin
               if (events.boot_press) begin
                  state <= st_boot;
               end else if (events.cont_press) begin
                  state <= st_run;
               end
            end
            default: state <= st_power_on;
         endcase
      end
   end

   assign cpu_reset = (state == st_power_on) || (state == st_reset);
   assign cpu_boot  = (state == st_boot);
   assign cpu_halt  = (state == st_halted);

   // --------------------------------------------------
   // step rate, replaces the divided cpu clock
   // --------------------------------------------------

   always_ff @(posedge clk100) begin
      if (reset) begin
         rate_cnt <= '0;
      end else begin
         rate_cnt <= rate_cnt + 1'b1;
      end
   end

   // highest set switch of 6..0 wins, switch 7 is not looked at
   always_comb begin
      rate_sel = '0;
      for (int i = 0; i < num_rates - 1; i++) begin
         if (slideswitch[i]) begin
            rate_sel = rate_sel_w'(i + 1);
         end
      end
   end

   always_comb begin
      case (rate_sel)
         3'd7:    rate_log = rate_log_w'(rate_slow_log);
         3'd6:    rate_log = 4'd7;
         3'd5:    rate_log = 4'd6;
         3'd4:    rate_log = 4'd5;
         3'd3:    rate_log = 4'd3;
         3'd2:    rate_log = 4'd2;
         3'd1:    rate_log = 4'd1;
         default: rate_log = 4'd0;   // no switch, step every cycle
      endcase
   end

   assign rate_mask = ~({rate_slow_log{1'b1}} << rate_log);

   // one pulse per 2**k cycles, only while running
   assign cpu_step = (state == st_run) && ((rate_cnt & rate_mask) == rate_mask);

endmodule

//--- fpga_panel.f
design/board_pkg.sv
design/panel_pkg.sv
design/panel_if.sv
design/button_conditioner.sv
design/run_control.sv
design/pc_display.sv
design/fpga_panel.sv
test/fpga_panel_tb.sv

//--- test/fpga_panel_tb.sv
`timescale 1ns/1ps

module fpga_panel_tb;
   import board_pkg::*;
   import panel_pkg::*;

   localparam int clk_period   = 4;
   localparam int press_limit  = 64;    // cycles to wait for a press to act
   localparam int press_settle = 40;
   localparam int glitch_count = 40;
   localparam int num_settings = 20;
   localparam int step_hold    = 300;
   localparam int slow_cycles  = 4200;  // covers one full slow step period
   localparam int halt_cycles  = 200;
   localparam int num_patterns = 8;
   localparam int pattern_hold = 40;
   localparam int mixed_cycles = 4000;
   localparam int watchdog_cycles = 40 + glitch_count * (debounce_cycles + 12)
      + 6 * (press_limit + press_settle + 1) + num_settings * step_hold + slow_cycles
      + halt_cycles + num_patterns * pattern_hold + mixed_cycles + 1000;

   logic                   clk100;
   logic                   reset;
   logic [num_buttons-1:0] button;
   logic [7:0]             slideswitch;
   logic [pc_width-1:0]    pc;
   logic [num_digits-1:0]  dots;
   logic                   cpu_reset;
   logic                   cpu_boot;
   logic                   cpu_halt;
   logic                   cpu_step;
   logic [7:0]             sevenseg;
   logic [num_digits-1:0]  sevenseg_an;

   // values for the next rising edge
   logic                   drv_reset;
   logic [num_buttons-1:0] drv_button;
   logic [7:0]             drv_switch;
   logic [pc_width-1:0]    drv_pc;
   logic [num_digits-1:0]  drv_dots;

   // model state
   logic [num_buttons-1:0] m_sync1;
   logic [num_buttons-1:0] m_sync2;
   logic [num_buttons-1:0] m_deb;
   logic [num_buttons-1:0] m_deb_q;
   logic [num_buttons-1:0] m_press;
   int                     m_count [num_buttons];
   seq_state_t             m_state;
   int                     m_hold;       // reset cycles still to go
   int                     m_rate;
   int                     m_dwell;
   int                     m_digit;
   bit                     m_digit_ok;
   logic [num_digits-1:0]  m_an;
   logic [7:0]             m_seg;
   bit                     m_seg_ok;

   fpga_panel uut (.*);

   initial begin
      clk100 = 1'b0;
      forever #(clk_period / 2) clk100 = ~clk100;
   end

   initial begin
      #(watchdog_cycles * clk_period);
      $display("timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   // --------------------------------------------------
   // reference model
   // --------------------------------------------------

   // lit segments as ones, a in bit 0, g in bit 6
   function automatic logic [6:0] seg_low(input logic [3:0] value);
      logic [6:0] lit;
      case (value)
         4'h0: lit = 7'h3f;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5b;
         4'h3: lit = 7'h4f;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6d;
         4'h6: lit = 7'h7d;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7f;
         4'h9: lit = 7'h6f;
         4'ha: lit = 7'h77;
         4'hb: lit = 7'h7c;
         4'hc: lit = 7'h39;
         4'hd: lit = 7'h5e;
         4'he: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   // log2 of the step period, later switches override earlier ones
   function automatic int step_log(input logic [7:0] sw);
      int k;
      k = 0;
      for (int i = 0; i <= 6; i++) begin
         if (sw[i]) begin
            case (i)
               0: k = 1;
               1: k = 2;
               2: k = 3;
               3: k = 5;
               4: k = 6;
               5: k = 7;
               default: k = rate_slow_log;
            endcase
         end
      end
      return k;
   endfunction

   function automatic logic expected_step();
      int period;
      period = 1 << step_log(slideswitch);
      return (m_state == st_run) && (m_rate % period == period - 1);
   endfunction

   task automatic model_update();
      logic [15:0] pc_wide;
      pc_wide = 16'(pc);
      m_seg_ok = m_digit_ok;   // segments follow the digit lit before the edge
      if (m_digit_ok) m_seg = {~dots[m_digit], seg_low(4'(pc_wide >> (4 * m_digit)))};
      if (reset) begin
         m_dwell    = 0;
         m_digit    = 0;
         m_digit_ok = 1'b1;
         m_an       = 4'b1110;
      end else begin
         m_an = ~(4'b0001 << m_digit);
         m_dwell++;
         if (m_dwell == digit_cycles) begin
            m_dwell = 0;
            m_digit = (m_digit + 1) % num_digits;
         end
      end

      if (reset) begin
         m_state = st_power_on;
         m_hold  = reset_hold_cycles;
      end else if (m_press[btn_reset]) begin
         m_state = st_reset;
         m_hold  = reset_hold_cycles;
      end else begin
         case (m_state)
            st_power_on, st_reset: begin
               m_hold--;
               if (m_hold == 0) m_state = st_boot;
            end
            st_boot: m_state = st_run;
            st_run: begin
               if (m_press[btn_boot]) m_state = st_boot;
               else if (m_press[btn_halt]) m_state = st_halted;
            end
            st_halted: begin
               if (m_press[btn_boot]) m_state = st_boot;
               else if (m_press[btn_cont]) m_state = st_run;
            end
            default: m_state = st_power_on;
         endcase
      end
      m_rate = reset ? 0 : (m_rate + 1) % (1 << rate_slow_log);

      // button path, last stage first
      if (reset) begin
         m_sync1 = '0;
         m_sync2 = '0;
         m_deb   = '0;
         m_deb_q = '0;
         m_press = '0;
         for (int i = 0; i < num_buttons; i++) m_count[i] = 0;
      end else begin
         m_press = m_deb & ~m_deb_q;
         m_deb_q = m_deb;
         for (int i = 0; i < num_buttons; i++) begin
            if (m_sync2[i] == m_deb[i]) begin
               m_count[i] = 0;
            end else begin
               m_count[i]++;
               if (m_count[i] == debounce_cycles) begin   // steady long enough
                  m_deb[i]   = m_sync2[i];
                  m_count[i] = 0;
               end
            end
         end
         m_sync2 = m_sync1;
         m_sync1 = button;
      end
   endtask

   // --------------------------------------------------
   // checks and cycle driver
   // --------------------------------------------------

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected) begin
         $display("[FAIL] %0t ns: %s is %0h, expected %0h (model state %s)",
                  $time, what, got, expected, m_state.name());
         $display("Simulation failed");
         $fatal(1, "mismatch on %s", what);
      end
   endtask

   task automatic compare_outputs();
      check("cpu_reset", cpu_reset, m_state == st_power_on || m_state == st_reset);
      check("cpu_boot", cpu_boot, m_state == st_boot);
      check("cpu_halt", cpu_halt, m_state == st_halted);
      check("cpu_step", cpu_step, expected_step());
      check("sevenseg_an", sevenseg_an, m_an);
      if (m_seg_ok) check("sevenseg", sevenseg, m_seg);
   endtask

   task automatic tick();
      @(posedge clk100);
      model_update();        // sees the inputs the DUT just sampled
      reset       <= drv_reset;
      button      <= drv_button;
      slideswitch <= drv_switch;
      pc          <= drv_pc;
      dots        <= drv_dots;
      @(negedge clk100);
      compare_outputs();
   endtask

   function automatic logic effect_seen(input btn_t b);
      case (b)
         btn_reset: return cpu_reset;
         btn_boot:  return cpu_boot;
         btn_halt:  return cpu_halt;
         default:   return !cpu_halt;
      endcase
   endfunction

   // hold one button, time its effect, then release and let it settle
   task automatic timed_press(input btn_t b);
      int lat;
      bit seen;
      lat  = 0;
      seen = 1'b0;
      drv_button[b] = 1'b1;
      tick();
      while (!seen && lat < press_limit) begin
         tick();
         if (effect_seen(b)) seen = 1'b1;
         else lat++;
      end
      check("press latency", lat, 2 + debounce_cycles + 1);
      drv_button[b] = 1'b0;
      repeat (press_settle) tick();
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial begin
      int unsigned first_draw;
      int          held;
      int          boots;
      int          len;
      int          idx;
      int          pick;
      first_draw  = $urandom(32'heded_7c89);
      reset       = 1'b1;
      button      = '0;
      slideswitch = '0;
      pc          = '0;
      dots        = '0;
      drv_reset   = 1'b1;
      drv_button  = '0;
      drv_switch  = '0;
      drv_pc      = '0;
      drv_dots    = '0;
      held        = 0;
      boots       = 0;

      // power on
      tick();
      drv_reset = 1'b0;
      repeat (30) begin
         tick();
         if (!reset && cpu_reset) held++;
         if (cpu_boot) boots++;
         if (cpu_reset || cpu_boot) check("step or halt before run", {cpu_step, cpu_halt}, 0);
      end
      check("reset hold cycles", held, reset_hold_cycles);
      check("boot pulses", boots, 1);

      // short glitches must not reach the sequencer
      repeat (glitch_count) begin
         idx = $urandom % num_buttons;
         len = 1 + $urandom % (debounce_cycles - 1);
         drv_button[idx] = 1'b1;
         repeat (len) tick();
         drv_button[idx] = 1'b0;
         repeat (4 + $urandom % 8) tick();
      end
      check("controls after glitches", {cpu_reset, cpu_boot, cpu_halt}, 3'b000);
      timed_press(btn_halt);
      timed_press(btn_cont);
      timed_press(btn_boot);
      timed_press(btn_reset);

      // step rates, switch 7 random
      repeat (num_settings) begin
         drv_switch = 8'($urandom);
         repeat (step_hold) tick();
      end
      drv_switch = {1'($urandom), 7'b100_0000};
      repeat (slow_cycles) tick();
      timed_press(btn_halt);
      drv_switch = '0;
      repeat (halt_cycles) begin
         tick();
         check("step while halted", cpu_step, 0);
      end
      timed_press(btn_cont);

      // display scan
      repeat (num_patterns) begin
         drv_pc   = pc_width'($urandom);
         drv_dots = num_digits'($urandom);
         repeat (pattern_hold) begin
            tick();
            check("anodes one hot", $countones(~sevenseg_an), 1);
         end
      end

      // everything at once
      repeat (mixed_cycles) begin
         pick = $urandom % 100;
         if (pick < 2) begin
            idx = $urandom % num_buttons;
            drv_button[idx] = ~drv_button[idx];
         end
         if (pick == 2) drv_switch = 8'($urandom);
         if (pick == 3) drv_dots = num_digits'($urandom);
         if (pick < 20) drv_pc = pc_width'($urandom);
         tick();
      end

      $display("Simulation passed");
      $finish;
   end

endmodule
